//--- hdl/lc4_dual_config.svh
`ifndef LC4_DUAL_CONFIG_SVH
`define LC4_DUAL_CONFIG_SVH

// data path and instruction word width
`define LC4_XLEN 16

// architectural register file
`define LC4_NREG 8
`define LC4_RSEL_W 3

// first fetch address out of reset
`define LC4_RESET_PC 16'h8200

// lane 0 is the older slot (A), lane 1 the younger (B)
`define LC4_LANES 2

// opcodes of the executed subset, all others retire as no-ops
`define LC4_OP_ARITH 4'b0001
`define LC4_OP_LOGIC 4'b0101
`define LC4_OP_CONST 4'b1001

`endif

//--- hdl/lc4_dual_pkg.sv
`include "lc4_dual_config.svh"

package lc4_dual_pkg;

    // register form: ADD/MUL/SUB, AND/NOT/OR/XOR
    typedef struct packed {
        logic [3:0]              opcode;
        logic [`LC4_RSEL_W-1:0]  rd;
        logic [`LC4_RSEL_W-1:0]  rs;
        logic [2:0]              subop;
        logic [`LC4_RSEL_W-1:0]  rt;
    } insn_reg_t;

    // immediate form, imm_flag overlays the top subop bit
    typedef struct packed {
        logic [3:0]              opcode;
        logic [`LC4_RSEL_W-1:0]  rd;
        logic [`LC4_RSEL_W-1:0]  rs;
        logic                    imm_flag;
        logic [4:0]              imm5;
    } insn_imm_t;

    typedef struct packed {
        logic [3:0]              opcode;
        logic [`LC4_RSEL_W-1:0]  rd;
        logic [8:0]              imm9;
    } insn_const_t;

    typedef union packed {
        insn_reg_t   r;
        insn_imm_t   i;
        insn_const_t c;
    } insn_u;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_MUL,
        ALU_SUB,
        ALU_ADDI,
        ALU_AND,
        ALU_NOT,
        ALU_OR,
        ALU_XOR,
        ALU_ANDI,
        ALU_CONST
    } alu_op_e;

    // decoded instruction, issue to execute
    typedef struct packed {
        logic                    valid;
        logic [`LC4_XLEN-1:0]    pc;
        insn_u                   insn;
        alu_op_e                 alu_op;
        logic [`LC4_RSEL_W-1:0]  rs_sel;
        logic [`LC4_RSEL_W-1:0]  rt_sel;
        logic                    rs_re;
        logic                    rt_re;
        logic [`LC4_RSEL_W-1:0]  rd_sel;
        logic                    rd_we;
        logic [`LC4_XLEN-1:0]    imm;
        logic [`LC4_XLEN-1:0]    rs_data;
        logic [`LC4_XLEN-1:0]    rt_data;
    } uop_t;

    // finished instruction in W
    typedef struct packed {
        logic                    valid;
        logic [`LC4_XLEN-1:0]    pc;
        insn_u                   insn;
        logic                    we;
        logic [`LC4_RSEL_W-1:0]  rd;
        logic [`LC4_XLEN-1:0]    data;
    } wb_t;

    typedef struct packed {
        logic [`LC4_LANES-1:0]                  we;
        logic [`LC4_LANES-1:0][`LC4_RSEL_W-1:0] sel;
        logic [`LC4_LANES-1:0][`LC4_XLEN-1:0]   data;
    } bypass_t;

    // younger lanes override older ones, otherwise the stored value
    function automatic logic [`LC4_XLEN-1:0] bypass_pick(
        input logic [`LC4_RSEL_W-1:0] sel,
        input logic [`LC4_XLEN-1:0]   reg_val,
        input bypass_t                byp
    );
        logic [`LC4_XLEN-1:0] val;
        val = reg_val;
        for (int l = 0; l < `LC4_LANES; l++) begin
            if (byp.we[l] && byp.sel[l] == sel) begin
                val = byp.data[l];
            end
        end
        return val;
    endfunction

endpackage

//--- hdl/lc4_dual_issue.sv
`include "lc4_dual_config.svh"

module lc4_dual_issue (
    input  logic                                   gwe,
    input  logic                                   i_rst_n,
    input  lc4_dual_pkg::insn_u                    i_insn_a,
    input  lc4_dual_pkg::insn_u                    i_insn_b,
    input  logic [`LC4_LANES-1:0][`LC4_XLEN-1:0]   i_rs_data,
    input  logic [`LC4_LANES-1:0][`LC4_XLEN-1:0]   i_rt_data,
    output logic [`LC4_XLEN-1:0]                   o_pc,
    output logic [`LC4_LANES-1:0][`LC4_RSEL_W-1:0] o_rsel,
    output logic [`LC4_LANES-1:0][`LC4_RSEL_W-1:0] o_tsel,
    output lc4_dual_pkg::uop_t [`LC4_LANES-1:0]    o_uop
);

    logic [`LC4_XLEN-1:0]                 pc_q;
    logic [`LC4_LANES-1:0]                d_valid_q;
    logic [`LC4_LANES-1:0][`LC4_XLEN-1:0] d_pc_q;
    lc4_dual_pkg::insn_u [`LC4_LANES-1:0] d_insn_q;
    lc4_dual_pkg::uop_t [`LC4_LANES-1:0]  dec;
    logic                                 split;

    function automatic lc4_dual_pkg::uop_t decode(
        input lc4_dual_pkg::insn_u  insn,
        input logic [`LC4_XLEN-1:0] pc,
        input logic                 valid
    );
        lc4_dual_pkg::uop_t u;
        u        = '0;
        u.valid  = valid;
        u.pc     = pc;
        u.insn   = insn;
        u.rs_sel = insn.r.rs;
        u.rt_sel = insn.r.rt;
        u.rd_sel = insn.r.rd;
        u.alu_op = lc4_dual_pkg::ALU_NOP;
        case (insn.r.opcode)
            `LC4_OP_ARITH: begin
                if (insn.i.imm_flag) begin
                    u.alu_op = lc4_dual_pkg::ALU_ADDI;
                    u.imm    = {{(`LC4_XLEN-5){insn.i.imm5[4]}}, insn.i.imm5};
                end else begin
                    case (insn.r.subop[1:0])
                        2'd0:    u.alu_op = lc4_dual_pkg::ALU_ADD;
                        2'd1:    u.alu_op = lc4_dual_pkg::ALU_MUL;
                        2'd2:    u.alu_op = lc4_dual_pkg::ALU_SUB;
                        // DIV has no divider, stays a no-op
                        default: u.alu_op = lc4_dual_pkg::ALU_NOP;
                    endcase
                    u.rt_re = (u.alu_op != lc4_dual_pkg::ALU_NOP);
                end
                u.rs_re = (u.alu_op != lc4_dual_pkg::ALU_NOP);
            end
            `LC4_OP_LOGIC: begin
                if (insn.i.imm_flag) begin
                    u.alu_op = lc4_dual_pkg::ALU_ANDI;
                    u.imm    = {{(`LC4_XLEN-5){insn.i.imm5[4]}}, insn.i.imm5};
                end else begin
                    case (insn.r.subop[1:0])
                        2'd0:    u.alu_op = lc4_dual_pkg::ALU_AND;
                        2'd1:    u.alu_op = lc4_dual_pkg::ALU_NOT;
                        2'd2:    u.alu_op = lc4_dual_pkg::ALU_OR;
                        default: u.alu_op = lc4_dual_pkg::ALU_XOR;
                    endcase
                    u.rt_re = (u.alu_op != lc4_dual_pkg::ALU_NOT);
                end
                u.rs_re = 1'b1;
            end
            `LC4_OP_CONST: begin
                u.alu_op = lc4_dual_pkg::ALU_CONST;
                u.imm    = {{(`LC4_XLEN-9){insn.c.imm9[8]}}, insn.c.imm9};
            end
            default: ;
        endcase
        u.rd_we = valid && (u.alu_op != lc4_dual_pkg::ALU_NOP);
        u.rs_re = valid && u.rs_re;
        u.rt_re = valid && u.rt_re;
        return u;
    endfunction

    always_comb begin
        for (int l = 0; l < `LC4_LANES; l++) begin
            dec[l]            = decode(d_insn_q[l], d_pc_q[l], d_valid_q[l]);
            o_rsel[l]         = dec[l].rs_sel;
            o_tsel[l]         = dec[l].rt_sel;
            o_uop[l]          = dec[l];
            o_uop[l].rs_data  = i_rs_data[l];
            o_uop[l].rt_data  = i_rt_data[l];
        end
        // B needs A
        split = dec[0].rd_we &&
                ((dec[1].rs_re && dec[1].rs_sel == dec[0].rd_sel) ||
                 (dec[1].rt_re && dec[1].rt_sel == dec[0].rd_sel));
        if (split) begin
            o_uop[1].valid = 1'b0;
            o_uop[1].rd_we = 1'b0;
        end
    end

    // on a split the held B moves into slot A, paired with the word at the PC
    always_ff @(posedge gwe) begin
        if (split) begin
            d_pc_q[0]   <= d_pc_q[1];
            d_insn_q[0] <= d_insn_q[1];
            d_pc_q[1]   <= pc_q;
            d_insn_q[1] <= i_insn_a;
        end else begin
            d_pc_q[0]   <= pc_q;
            d_insn_q[0] <= i_insn_a;
            d_pc_q[1]   <= pc_q + 1'b1;
            d_insn_q[1] <= i_insn_b;
        end
    end

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            pc_q      <= `LC4_RESET_PC;
            d_valid_q <= '0;
        end else begin
            pc_q      <= split ? pc_q + 1'b1 : pc_q + 2'd2;
            d_valid_q <= '1;
        end
    end

    assign o_pc = pc_q;

    a_pc_step: assert property (@(posedge gwe) disable iff (!i_rst_n)
        $past(i_rst_n) |-> (pc_q == $past(pc_q) + 1'b1) || (pc_q == $past(pc_q) + 2'd2));

    a_split_hold: assert property (@(posedge gwe) disable iff (!i_rst_n)
        split |-> !o_uop[1].valid ##1 (d_valid_q[0] && d_pc_q[0] == $past(d_pc_q[1])));

endmodule

//--- hdl/lc4_dual_lane.sv
`include "lc4_dual_config.svh"

module lc4_dual_lane (
    input  logic                  gwe,
    input  logic                  i_rst_n,
    input  lc4_dual_pkg::uop_t    i_uop,
    input  lc4_dual_pkg::bypass_t i_bypass,
    output lc4_dual_pkg::wb_t     o_wb
);

    lc4_dual_pkg::uop_t   x_q;
    lc4_dual_pkg::wb_t    w_q;
    logic [`LC4_XLEN-1:0] rs_val;
    logic [`LC4_XLEN-1:0] rt_val;
    logic [`LC4_XLEN-1:0] alu_res;

    // D to X
    always_ff @(posedge gwe) begin
        x_q <= i_uop;
        if (!i_rst_n) begin
            x_q.valid <= 1'b0;
        end
    end

    // W of lane B first, then W of lane A, then the value read in D
    assign rs_val = lc4_dual_pkg::bypass_pick(x_q.rs_sel, x_q.rs_data, i_bypass);
    assign rt_val = lc4_dual_pkg::bypass_pick(x_q.rt_sel, x_q.rt_data, i_bypass);

    always_comb begin
        case (x_q.alu_op)
            lc4_dual_pkg::ALU_ADD: begin
                alu_res = rs_val + rt_val;
            end
            lc4_dual_pkg::ALU_MUL: begin
                // low half of the product only
                alu_res = rs_val * rt_val;
            end
            lc4_dual_pkg::ALU_SUB: begin
                alu_res = rs_val - rt_val;
            end
            lc4_dual_pkg::ALU_ADDI: begin
                alu_res = rs_val + x_q.imm;
            end
            lc4_dual_pkg::ALU_AND: begin
                alu_res = rs_val & rt_val;
            end
            lc4_dual_pkg::ALU_NOT: begin
                alu_res = ~rs_val;
            end
            lc4_dual_pkg::ALU_OR: begin
                alu_res = rs_val | rt_val;
            end
            lc4_dual_pkg::ALU_XOR: begin
                alu_res = rs_val ^ rt_val;
            end
            lc4_dual_pkg::ALU_ANDI: begin
                alu_res = rs_val & x_q.imm;
            end
            lc4_dual_pkg::ALU_CONST: begin
                alu_res = x_q.imm;
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

    // X to W
    always_ff @(posedge gwe) begin
        w_q.valid <= x_q.valid;
        w_q.pc    <= x_q.pc;
        w_q.insn  <= x_q.insn;
        w_q.we    <= x_q.valid && x_q.rd_we;
        w_q.rd    <= x_q.rd_sel;
        w_q.data  <= alu_res;
        if (!i_rst_n) begin
            w_q.valid <= 1'b0;
            w_q.we    <= 1'b0;
        end
    end

    assign o_wb = w_q;

    // a valid X slot carries a fully known operation, write enable and target
    a_x_decoded: assert property (@(posedge gwe) disable iff (!i_rst_n)
        x_q.valid |-> !$isunknown({x_q.alu_op, x_q.rd_we, x_q.rd_sel}));

endmodule

//--- hdl/lc4_dual_regfile.sv
`include "lc4_dual_config.svh"

module lc4_dual_regfile (
    input  logic                                   gwe,
    input  logic                                   i_rst_n,
    input  logic [`LC4_LANES-1:0][`LC4_RSEL_W-1:0] i_rsel,
    input  logic [`LC4_LANES-1:0][`LC4_RSEL_W-1:0] i_tsel,
    input  lc4_dual_pkg::bypass_t                  i_bypass,
    output logic [`LC4_LANES-1:0][`LC4_XLEN-1:0]   o_rs_data,
    output logic [`LC4_LANES-1:0][`LC4_XLEN-1:0]   o_rt_data
);

    logic [`LC4_XLEN-1:0] regs_q [`LC4_NREG];

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            for (int r = 0; r < `LC4_NREG; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            // lane B is written last and keeps a collision
            for (int l = 0; l < `LC4_LANES; l++) begin
                if (i_bypass.we[l]) begin
                    regs_q[i_bypass.sel[l]] <= i_bypass.data[l];
                end
            end
        end
    end

    // write-through, a read sees the value written on the coming edge
    always_comb begin
        for (int l = 0; l < `LC4_LANES; l++) begin
            o_rs_data[l] = lc4_dual_pkg::bypass_pick(i_rsel[l], regs_q[i_rsel[l]], i_bypass);
            o_rt_data[l] = lc4_dual_pkg::bypass_pick(i_tsel[l], regs_q[i_tsel[l]], i_bypass);
        end
    end

endmodule

//--- hdl/lc4_dual_retire.sv
`include "lc4_dual_config.svh"

module lc4_dual_retire (
    input  lc4_dual_pkg::wb_t [`LC4_LANES-1:0] i_wb,
    output lc4_dual_pkg::bypass_t              o_bypass,
    output lc4_dual_pkg::wb_t [`LC4_LANES-1:0] o_ret
);

    logic [`LC4_LANES-1:0] shadowed;

    always_comb begin
        for (int l = 0; l < `LC4_LANES; l++) begin
            // a younger write to the same register hides this one
            shadowed[l] = 1'b0;
            for (int m = l + 1; m < `LC4_LANES; m++) begin
                if (i_wb[m].we && i_wb[m].rd == i_wb[l].rd) begin
                    shadowed[l] = 1'b1;
                end
            end
            o_bypass.we[l]   = i_wb[l].we && !shadowed[l];
            o_bypass.sel[l]  = i_wb[l].rd;
            o_bypass.data[l] = i_wb[l].data;
        end
    end

    // retire records keep the architectural write of every lane
    assign o_ret = i_wb;

    // lane B only retires next to the instruction right before it
    always_comb begin
        if (i_wb[1].valid) begin
            a_ret_order: assert final (i_wb[0].valid && i_wb[1].pc == i_wb[0].pc + 1'b1);
        end
    end

endmodule

//--- hdl/lc4_dual_core.sv
`include "lc4_dual_config.svh"

module lc4_dual_core (
    input  logic                               gwe,
    input  logic                               i_rst_n,
    output logic [`LC4_XLEN-1:0]               o_pc,
    input  lc4_dual_pkg::insn_u                i_insn_a,
    input  lc4_dual_pkg::insn_u                i_insn_b,
    output lc4_dual_pkg::wb_t [`LC4_LANES-1:0] o_ret
);

    logic [`LC4_LANES-1:0][`LC4_RSEL_W-1:0] rsel;
    logic [`LC4_LANES-1:0][`LC4_RSEL_W-1:0] tsel;
    logic [`LC4_LANES-1:0][`LC4_XLEN-1:0]   rs_data;
    logic [`LC4_LANES-1:0][`LC4_XLEN-1:0]   rt_data;
    lc4_dual_pkg::uop_t [`LC4_LANES-1:0]    uop;
    lc4_dual_pkg::wb_t [`LC4_LANES-1:0]     wb;
    lc4_dual_pkg::bypass_t                  bypass;

    lc4_dual_issue u_issue (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_insn_a  (i_insn_a),
        .i_insn_b  (i_insn_b),
        .i_rs_data (rs_data),
        .i_rt_data (rt_data),
        .o_pc      (o_pc),
        .o_rsel    (rsel),
        .o_tsel    (tsel),
        .o_uop     (uop)
    );

    // lane 0 is A, lane 1 is B
    for (genvar l = 0; l < `LC4_LANES; l++) begin : g_lane
        lc4_dual_lane u_lane (
            .gwe      (gwe),
            .i_rst_n  (i_rst_n),
            .i_uop    (uop[l]),
            .i_bypass (bypass),
            .o_wb     (wb[l])
        );
    end

    lc4_dual_regfile u_regfile (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_rsel    (rsel),
        .i_tsel    (tsel),
        .i_bypass  (bypass),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    lc4_dual_retire u_retire (
        .i_wb     (wb),
        .o_bypass (bypass),
        .o_ret    (o_ret)
    );

endmodule

//--- testbench/lc4_dual_prog.svh
`ifndef LC4_DUAL_PROG_SVH
`define LC4_DUAL_PROG_SVH

// columns: test name, instruction word, 1 when the CONST imm9 comes from $random
// subop for arith is 0 ADD, 1 MUL, 2 SUB, 3 DIV; for logic 0 AND, 1 NOT, 2 OR, 3 XOR
task automatic load_table();
    add_entry("const_r1_rand",  const_form(3'd1, 9'h000), 1'b1);
    add_entry("const_r2_rand",  const_form(3'd2, 9'h000), 1'b1);
    add_entry("const_r3_neg",   const_form(3'd3, 9'h1f0), 1'b0);
    add_entry("const_r4_rand",  const_form(3'd4, 9'h000), 1'b1);
    // producers two pairs back are read through write-through in D
    add_entry("add_w_to_d",     reg_form(`LC4_OP_ARITH, 3'd0, 3'd5, 3'd1, 3'd2), 1'b0);
    add_entry("mul_w_to_x",     reg_form(`LC4_OP_ARITH, 3'd1, 3'd6, 3'd3, 3'd4), 1'b0);
    add_entry("sub_both_lanes", reg_form(`LC4_OP_ARITH, 3'd2, 3'd7, 3'd5, 3'd6), 1'b0);
    add_entry("addi_neg",       imm_form(`LC4_OP_ARITH, 3'd0, 3'd1, 5'h19), 1'b0);
    add_entry("and_reg",        reg_form(`LC4_OP_LOGIC, 3'd0, 3'd1, 3'd5, 3'd2), 1'b0);
    add_entry("not_reg",        reg_form(`LC4_OP_LOGIC, 3'd1, 3'd2, 3'd3, 3'd0), 1'b0);
    add_entry("or_reg",         reg_form(`LC4_OP_LOGIC, 3'd2, 3'd3, 3'd7, 3'd0), 1'b0);
    add_entry("xor_reg",        reg_form(`LC4_OP_LOGIC, 3'd3, 3'd4, 3'd6, 3'd1), 1'b0);
    add_entry("andi_pos",       imm_form(`LC4_OP_LOGIC, 3'd5, 3'd4, 5'h0f), 1'b0);
    add_entry("const_pos",      const_form(3'd6, 9'h0ff), 1'b0);
    // B needs A, the pair splits
    add_entry("split_prod",     reg_form(`LC4_OP_ARITH, 3'd0, 3'd7, 3'd5, 3'd2), 1'b0);
    add_entry("split_cons",     reg_form(`LC4_OP_ARITH, 3'd2, 3'd0, 3'd7, 3'd3), 1'b0);
    add_entry("after_split",    reg_form(`LC4_OP_ARITH, 3'd1, 3'd1, 3'd7, 3'd6), 1'b0);
    add_entry("read_split",     reg_form(`LC4_OP_LOGIC, 3'd2, 3'd2, 3'd0, 3'd1), 1'b0);
    add_entry("not_split_rd",   reg_form(`LC4_OP_LOGIC, 3'd1, 3'd3, 3'd0, 3'd0), 1'b0);
    // both lanes write r4, lane B must win
    add_entry("same_rd_a",      reg_form(`LC4_OP_ARITH, 3'd0, 3'd4, 3'd1, 3'd2), 1'b0);
    add_entry("same_rd_b",      reg_form(`LC4_OP_LOGIC, 3'd3, 3'd4, 3'd3, 3'd6), 1'b0);
    add_entry("read_same_rd",   reg_form(`LC4_OP_ARITH, 3'd2, 3'd5, 3'd4, 3'd1), 1'b0);
    add_entry("addi_same_rd",   imm_form(`LC4_OP_ARITH, 3'd6, 3'd4, 5'h05), 1'b0);
    add_entry("nop_zero",       16'h0000, 1'b0);
    add_entry("nop_div",        reg_form(`LC4_OP_ARITH, 3'd3, 3'd1, 3'd2, 3'd3), 1'b0);
    add_entry("nop_jmp",        16'hc1c0, 1'b0);
    add_entry("read_after_nop", reg_form(`LC4_OP_LOGIC, 3'd0, 3'd7, 3'd1, 3'd5), 1'b0);
    // chain of splits back to back
    add_entry("const_r1_chain", const_form(3'd1, 9'h000), 1'b1);
    add_entry("chain_1",        reg_form(`LC4_OP_ARITH, 3'd0, 3'd2, 3'd1, 3'd1), 1'b0);
    add_entry("chain_2",        reg_form(`LC4_OP_LOGIC, 3'd3, 3'd3, 3'd2, 3'd7), 1'b0);
    add_entry("chain_3",        imm_form(`LC4_OP_LOGIC, 3'd0, 3'd3, 5'h1f), 1'b0);
endtask

`endif

//--- testbench/lc4_dual_tb.sv
`include "lc4_dual_config.svh"

module lc4_dual_tb;

    localparam int MAX_WAIT = 20;

    logic                               gwe;
    logic                               i_rst_n;
    logic [`LC4_XLEN-1:0]               o_pc;
    lc4_dual_pkg::insn_u                i_insn_a;
    lc4_dual_pkg::insn_u                i_insn_b;
    lc4_dual_pkg::wb_t [`LC4_LANES-1:0] o_ret;

    string               name_q[$];
    lc4_dual_pkg::insn_u insn_q[$];
    lc4_dual_pkg::wb_t   exp_q[$];
    integer              seed;
    int                  next_idx;

    lc4_dual_core u_lc4_dual_core (
        .gwe      (gwe),
        .i_rst_n  (i_rst_n),
        .o_pc     (o_pc),
        .i_insn_a (i_insn_a),
        .i_insn_b (i_insn_b),
        .o_ret    (o_ret)
    );

    always #10 gwe = ~gwe;

    function automatic lc4_dual_pkg::insn_u reg_form(
        input logic [3:0] op,
        input logic [2:0] sub,
        input logic [2:0] rd,
        input logic [2:0] rs,
        input logic [2:0] rt
    );
        return {op, rd, rs, sub, rt};
    endfunction

    function automatic lc4_dual_pkg::insn_u imm_form(
        input logic [3:0] op,
        input logic [2:0] rd,
        input logic [2:0] rs,
        input logic [4:0] imm5
    );
        return {op, rd, rs, 1'b1, imm5};
    endfunction

    function automatic lc4_dual_pkg::insn_u const_form(
        input logic [2:0] rd,
        input logic [8:0] imm9
    );
        return {`LC4_OP_CONST, rd, imm9};
    endfunction

    task automatic add_entry(
        input string               name,
        input lc4_dual_pkg::insn_u word,
        input bit                  draw_imm
    );
        lc4_dual_pkg::insn_u w;
        logic [31:0]         rnd;
        w = word;
        if (draw_imm) begin
            rnd = $random(seed);
            w.c.imm9 = rnd[8:0];
        end
        name_q.push_back(name);
        insn_q.push_back(w);
    endtask

    `include "lc4_dual_prog.svh"

    // architectural state walked in program order
    task automatic build_expected();
        logic [`LC4_XLEN-1:0] regs [`LC4_NREG];
        lc4_dual_pkg::insn_u  w;
        lc4_dual_pkg::wb_t    e;
        logic [`LC4_XLEN-1:0] vs;
        logic [`LC4_XLEN-1:0] vt;
        logic [`LC4_XLEN-1:0] simm5;
        for (int r = 0; r < `LC4_NREG; r++) begin
            regs[r] = '0;
        end
        for (int k = 0; k < insn_q.size(); k++) begin
            w       = insn_q[k];
            vs      = regs[w.r.rs];
            vt      = regs[w.r.rt];
            simm5   = {{(`LC4_XLEN-5){w.i.imm5[4]}}, w.i.imm5};
            e       = '0;
            e.valid = 1'b1;
            e.pc    = `LC4_RESET_PC + 16'(k);
            e.insn  = w;
            e.rd    = w.r.rd;
            e.we    = 1'b1;
            case (w.r.opcode)
                `LC4_OP_ARITH: begin
                    if (w.i.imm_flag) begin
                        e.data = vs + simm5;
                    end else begin
                        case (w.r.subop[1:0])
                            2'd0:    e.data = vs + vt;
                            2'd1:    e.data = vs * vt;
                            2'd2:    e.data = vs - vt;
                            // DIV retires without a write
                            default: e.we = 1'b0;
                        endcase
                    end
                end
                `LC4_OP_LOGIC: begin
                    if (w.i.imm_flag) begin
                        e.data = vs & simm5;
                    end else begin
                        case (w.r.subop[1:0])
                            2'd0:    e.data = vs & vt;
                            2'd1:    e.data = ~vs;
                            2'd2:    e.data = vs | vt;
                            default: e.data = vs ^ vt;
                        endcase
                    end
                end
                `LC4_OP_CONST: begin
                    e.data = {{(`LC4_XLEN-9){w.c.imm9[8]}}, w.c.imm9};
                end
                default: begin
                    e.we = 1'b0;
                end
            endcase
            if (e.we) begin
                regs[e.rd] = e.data;
            end
            exp_q.push_back(e);
        end
    endtask

    // words outside the table read as zero, a no-op
    function automatic lc4_dual_pkg::insn_u fetch_word(input logic [`LC4_XLEN-1:0] addr);
        logic [`LC4_XLEN-1:0] offs;
        offs = addr - `LC4_RESET_PC;
        if (32'(offs) < insn_q.size()) begin
            return insn_q[offs];
        end
        return '0;
    endfunction

    always @(posedge gwe) begin
        #1;
        i_insn_a = fetch_word(o_pc);
        i_insn_b = fetch_word(o_pc + 1'b1);
    end

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_insn(
        input string                name,
        input lc4_dual_pkg::insn_u  exp_insn,
        input lc4_dual_pkg::insn_u  act_insn,
        input logic [`LC4_XLEN-1:0] exp_pc,
        input logic [`LC4_XLEN-1:0] act_pc
    );
        if (act_pc !== exp_pc) begin
            $display("Fail %s: pc expected %h actual %h", name, exp_pc, act_pc);
            stop_with_failure();
        end
        if (act_insn !== exp_insn) begin
            $display("Fail %s: insn expected %h actual %h", name, exp_insn, act_insn);
            stop_with_failure();
        end
    endtask

    task automatic check_result(
        input string             name,
        input lc4_dual_pkg::wb_t exp,
        input lc4_dual_pkg::wb_t act
    );
        if (act.we !== exp.we) begin
            $display("Fail %s: write enable expected %b actual %b", name, exp.we, act.we);
            stop_with_failure();
        end
        if (exp.we && (act.rd !== exp.rd || act.data !== exp.data)) begin
            $display("Fail %s: expected r%0d=%h actual r%0d=%h",
                     name, exp.rd, exp.data, act.rd, act.data);
            stop_with_failure();
        end
    endtask

    task automatic consume_retire(input lc4_dual_pkg::wb_t act);
        if (next_idx < exp_q.size()) begin
            check_insn(name_q[next_idx], exp_q[next_idx].insn, act.insn,
                       exp_q[next_idx].pc, act.pc);
            check_result(name_q[next_idx], exp_q[next_idx], act);
            next_idx++;
        end
    endtask

    task automatic wait_retire();
        int waited;
        waited = 0;
        @(negedge gwe);
        while (o_ret[0].valid !== 1'b1 && o_ret[1].valid !== 1'b1) begin
            if (waited == MAX_WAIT) begin
                $display("timeout: nothing retired for %0d cycles", MAX_WAIT);
                stop_with_failure();
            end
            waited++;
            @(negedge gwe);
        end
    endtask

    initial begin
        gwe      = 1'b0;
        i_rst_n  = 1'b0;
        i_insn_a = '0;
        i_insn_b = '0;
        seed     = 32'ha859;
        next_idx = 0;
        load_table();
        build_expected();
        repeat (4) @(posedge gwe);
        #1;
        i_rst_n = 1'b1;
        if (o_pc !== `LC4_RESET_PC) begin
            $display("Fail reset_pc: expected %h actual %h", `LC4_RESET_PC, o_pc);
            stop_with_failure();
        end
        // first pair still needs D, X and W
        for (int e = 0; e < 3; e++) begin
            @(negedge gwe);
            if (o_ret[0].valid !== 1'b0 || o_ret[1].valid !== 1'b0) begin
                $display("retire valid seen %0d edges after reset release", e);
                stop_with_failure();
            end
        end
        while (next_idx < exp_q.size()) begin
            wait_retire();
            // lane A is older within a cycle
            for (int l = 0; l < `LC4_LANES; l++) begin
                if (o_ret[l].valid === 1'b1) begin
                    consume_retire(o_ret[l]);
                end
            end
        end
        if (next_idx == exp_q.size()) begin
            $display("Simulation completed successfully");
        end else begin
            $display("only %0d of %0d instructions retired", next_idx, exp_q.size());
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- lc4_dual.f
+incdir+hdl
+incdir+testbench
hdl/lc4_dual_pkg.sv
hdl/lc4_dual_issue.sv
hdl/lc4_dual_lane.sv
hdl/lc4_dual_regfile.sv
hdl/lc4_dual_retire.sv
hdl/lc4_dual_core.sv
testbench/lc4_dual_tb.sv

//--- Makefile
TOP := lc4_dual_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f lc4_dual.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	@if grep -q "Simulation failed" sim.log; then echo "simulation FAILED"; exit 1; fi
	@grep -q "Simulation completed successfully" sim.log || \
		{ echo "no pass line in sim.log"; exit 1; }

lint:
	verilator --lint-only --timing -f lc4_dual.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
